// File: ber_counter.sv
// Counts hold at all ones once full and are only cleared by reset
`timescale 1ns/100ps

`include "sysele_consts.svh"

module ber_counter
   import sysele_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_i,
   input  ber_word_t sent_i,
   input  ber_word_t recv_i,
   input  logic      valid_i,
   status_if.ber     ber
);

   // Wide enough for every bit of a word in error
   localparam int ERR_W = $clog2(`SYSELE_BER_W + 1);

   ber_word_t        diff;
   logic [ERR_W-1:0] nerr;

   cnt_t                  err_q;
   cnt_t                  words_q;
   logic [`SYSELE_CNT_W:0] err_sum;

   // ------------------------------
   // Bit error count of one word
   // ------------------------------
   always_comb begin
      diff = sent_i ^ recv_i;
      nerr = '0;
      for (int i = 0; i < `SYSELE_BER_W; i++) begin
         nerr = nerr + ERR_W'(diff[i]);
      end
   end

   // Carry out means the error count is full
   assign err_sum = {1'b0, err_q} + (`SYSELE_CNT_W + 1)'(nerr);

   // ------------------------------
   // Saturating counters
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         err_q   <= '0;
         words_q <= '0;
      end else if (valid_i) begin
         err_q <= err_sum[`SYSELE_CNT_W] ? '1 : err_sum[`SYSELE_CNT_W-1:0];
         if (words_q != '1) begin
            words_q <= words_q + 1'b1;
         end
      end
   end

   assign ber.ber_errors = err_q;
   assign ber.ber_words  = words_q;

endmodule

// File: btn_edge.sv
// Buttons are raw levels without debounce, a bouncing press may give more than one pulse
`timescale 1ns/100ps

module btn_edge (
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic [2:0] btn_i,
   output logic [2:0] rise_o
);

   // Two-flop synchroniser
   logic [2:0] sync1_q;
   logic [2:0] sync2_q;

   // Previous synchronised level
   logic [2:0] edge_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         sync1_q <= '0;
         sync2_q <= '0;
         edge_q  <= '0;
      end else begin
         sync1_q <= btn_i;
         sync2_q <= sync1_q;
         edge_q  <= sync2_q;
      end
   end

   // High for the single cycle where the level has just gone up
   assign rise_o = sync2_q & ~edge_q;

endmodule

// File: compile.f
+incdir+.
sysele_pkg.sv
status_if.sv
btn_edge.sv
delay_ctrl_regs.sv
variable_delay.sv
ber_counter.sv
led_debug_mux.sv
sysele_top.sv
sysele_props.sv
tb_sysele.sv

// File: delay_ctrl_regs.sv
// Presses act only with the adjust bit set, centre always clears all three settings
`timescale 1ns/100ps

module delay_ctrl_regs
   import sysele_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic [2:0]  rise_i,
   input  dip_word_u   dip_i,
   status_if.cfg       cfg
);

   // Pulse positions in rise_i
   localparam int BTN_N = 2;
   localparam int BTN_S = 1;
   localparam int BTN_C = 0;

   // One setting per target, indexed by the enum value
   dly_sel_t dly_q [3];

   logic adj_ok;

   // ------------------------------
   // DIP decode
   // ------------------------------
   assign adj_ok = dip_i.adj.adj_en && (dip_i.adj.target != DLY_TGT_NONE);

   // ------------------------------
   // Setting registers
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dly_q <= '{default: '0};
      end else if (rise_i[BTN_C]) begin
         // Global clear ignores the switches
         dly_q <= '{default: '0};
      end else if (adj_ok) begin
         if (rise_i[BTN_N]) begin
            if (dly_q[dip_i.adj.target] != '1) begin
               dly_q[dip_i.adj.target] <= dly_q[dip_i.adj.target] + 1'b1;
            end
         end else if (rise_i[BTN_S]) begin
            // Hold at zero
            if (dly_q[dip_i.adj.target] != '0) begin
               dly_q[dip_i.adj.target] <= dly_q[dip_i.adj.target] - 1'b1;
            end
         end
      end
   end

   assign cfg.ad1_delay   = dly_q[DLY_TGT_AD1];
   assign cfg.ad2_delay   = dly_q[DLY_TGT_AD2];
   assign cfg.valid_delay = dly_q[DLY_TGT_VALID];

endmodule

// File: led_debug_mux.sv
// LEDs lag the DIP and the source by one cycle, undefined codes show all LEDs off
`timescale 1ns/100ps

`include "sysele_consts.svh"

module led_debug_mux
   import sysele_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  dip_word_u                dip_i,
   input  sample_t                  ad1_i,
   input  sample_t                  ad2_i,
   status_if.view                   view,
   output logic [`SYSELE_LED_W-1:0] led_o
);

   // Padding for the narrow delay settings
   localparam int PAD_W = `SYSELE_LED_W - `SYSELE_DLY_SEL_W;

   logic [`SYSELE_LED_W-1:0] sel_val;
   logic [`SYSELE_LED_W-1:0] led_q;

   // ------------------------------
   // Display code decode
   // ------------------------------
   always_comb begin
      case (dip_i.code)
         `SYSELE_CODE_AD1:       sel_val = ad1_i;
         `SYSELE_CODE_AD2:       sel_val = ad2_i;
         // Low byte only, the counters are wider than the LEDs
         `SYSELE_CODE_BER_ERR:   sel_val = view.ber_errors[`SYSELE_LED_W-1:0];
         `SYSELE_CODE_BER_WORDS: sel_val = view.ber_words[`SYSELE_LED_W-1:0];
         `SYSELE_CODE_DLY_AD1:   sel_val = {{PAD_W{1'b0}}, view.ad1_delay};
         `SYSELE_CODE_DLY_AD2:   sel_val = {{PAD_W{1'b0}}, view.ad2_delay};
         `SYSELE_CODE_DLY_VALID: sel_val = {{PAD_W{1'b0}}, view.valid_delay};
         default:                sel_val = '0;
      endcase
   end

   // Output register
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         led_q <= '0;
      end else begin
         led_q <= sel_val;
      end
   end

   assign led_o = led_q;

endmodule

// File: status_if.sv
// Status bundle in the clk_i domain, no handshake so readers sample the levels directly
`timescale 1ns/100ps

interface status_if
   import sysele_pkg::*;
();

   // Alignment settings
   dly_sel_t ad1_delay;
   dly_sel_t ad2_delay;
   dly_sel_t valid_delay;

   // BER statistics
   cnt_t ber_errors;
   cnt_t ber_words;

   // Setting register block
   modport cfg (
      output ad1_delay,
      output ad2_delay,
      output valid_delay
   );

   // Error counter
   modport ber (
      output ber_errors,
      output ber_words
   );

   // LED selector sees everything
   modport view (
      input ad1_delay,
      input ad2_delay,
      input valid_delay,
      input ber_errors,
      input ber_words
   );

endinterface

// File: sysele_consts.svh
// Assumes one 240 MHz clock domain and an 8-bit DIP word whose display codes are fixed here
`ifndef SYSELE_CONSTS_SVH
`define SYSELE_CONSTS_SVH

// ------------------------------
// Data path widths
// ------------------------------
`define SYSELE_SAMPLE_W 8
`define SYSELE_DLY_SEL_W 4
`define SYSELE_BER_W 6
`define SYSELE_CNT_W 16
`define SYSELE_LED_W 8

// Fixed part of every alignment delay, in cycles
`define SYSELE_DLY_MIN 32

// ------------------------------
// LED display codes on the DIP
// ------------------------------
`define SYSELE_CODE_AD1 8'd4
`define SYSELE_CODE_AD2 8'd5
`define SYSELE_CODE_BER_ERR 8'd6
`define SYSELE_CODE_BER_WORDS 8'd7

// Top DIP bit set selects a delay setting
`define SYSELE_CODE_DLY_AD1 8'd128
`define SYSELE_CODE_DLY_AD2 8'd129
`define SYSELE_CODE_DLY_VALID 8'd130

`endif

// File: sysele_pkg.sv
// Types for the sample alignment and debug logic, widths come from the constants header
package sysele_pkg;

`include "sysele_consts.svh"

   // ------------------------------
   // Data path words
   // ------------------------------
   typedef logic [`SYSELE_SAMPLE_W-1:0] sample_t;
   typedef logic [`SYSELE_DLY_SEL_W-1:0] dly_sel_t;
   typedef logic [`SYSELE_BER_W-1:0] ber_word_t;
   typedef logic [`SYSELE_CNT_W-1:0] cnt_t;

   // Setting picked by the low DIP bits in adjust mode
   typedef enum logic [1:0] {
      DLY_TGT_AD1   = 2'd0,
      DLY_TGT_AD2   = 2'd1,
      DLY_TGT_VALID = 2'd2,
      DLY_TGT_NONE  = 2'd3
   } dly_target_e;

   // ------------------------------
   // DIP word, two views
   // ------------------------------
   // Plain code for the LED selector, adjust fields for the button logic
   typedef union packed {
      logic [7:0] code;
      struct packed {
         logic        adj_en;
         logic [4:0]  rsvd;
         dly_target_e target;
      } adj;
   } dip_word_u;

endpackage

// File: sysele_props.sv
// Bound into the button, setting and counter blocks with unused ports tied to zero
`timescale 1ns/100ps

`include "sysele_consts.svh"

module sysele_props
   import sysele_pkg::*;
(
   input logic                           clk_i,
   input logic                           rst_i,
   input logic [2:0]                     rise_i,
   input cnt_t                           errors_i,
   input cnt_t                           words_i,
   input logic [3*`SYSELE_DLY_SEL_W-1:0] settings_i
);

   // A press gives one pulse, never two in a row
   a_rise_single: assert property (@(posedge clk_i) disable iff (rst_i)
      (rise_i & $past(rise_i)) == 3'b000)
      else $error("button pulse lasted two cycles");

   // ------------------------------
   // Counters only move up
   // ------------------------------
   a_err_mono: assert property (@(posedge clk_i) disable iff (rst_i)
      !$past(rst_i) |-> errors_i >= $past(errors_i))
      else $error("error count decreased");

   a_words_mono: assert property (@(posedge clk_i) disable iff (rst_i)
      !$past(rst_i) |-> words_i >= $past(words_i))
      else $error("word count decreased");

   a_reset_clear: assert property (@(posedge clk_i) rst_i |=> settings_i == '0)
      else $error("delay settings not cleared by reset");

endmodule

bind btn_edge sysele_props u_btn_props (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .rise_i     (rise_o),
   .errors_i   ('0),
   .words_i    ('0),
   .settings_i ('0)
);

bind ber_counter sysele_props u_ber_props (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .rise_i     (3'b000),
   .errors_i   (err_q),
   .words_i    (words_q),
   .settings_i ('0)
);

bind delay_ctrl_regs sysele_props u_dly_props (
   .clk_i      (clk_i),
   .rst_i      (rst_i),
   .rise_i     (rise_i),
   .errors_i   ('0),
   .words_i    ('0),
   .settings_i ({dly_q[2], dly_q[1], dly_q[0]})
);

// File: sysele_top.sv
// Single clock domain with synchronous active-high reset, buttons are raw asynchronous levels
`timescale 1ns/100ps

`include "sysele_consts.svh"

module sysele_top (
   input  logic                        clk_i,
   input  logic                        rst_i,

   // Push buttons, active high
   input  logic                        btn_n_i,
   input  logic                        btn_s_i,
   input  logic                        btn_c_i,

   // Display code or adjust mode
   input  logic [7:0]                  dip_i,

   // ADC channels and their strobe
   input  logic [`SYSELE_SAMPLE_W-1:0] ad1_i,
   input  logic [`SYSELE_SAMPLE_W-1:0] ad2_i,
   input  logic                        ad_valid_i,

   // Raw BER words
   input  logic [`SYSELE_BER_W-1:0]    ber_sent_i,
   input  logic [`SYSELE_BER_W-1:0]    ber_recv_i,
   input  logic                        ber_valid_i,

   // Aligned samples
   output logic [`SYSELE_SAMPLE_W-1:0] ad1_o,
   output logic [`SYSELE_SAMPLE_W-1:0] ad2_o,
   output logic                        ad_valid_o,

   output logic [`SYSELE_LED_W-1:0]    led_o
);

   logic [2:0] btn_rise;

   status_if u_status ();

   // ------------------------------
   // Buttons and settings
   // ------------------------------
   btn_edge u_btn_edge (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .btn_i  ({btn_n_i, btn_s_i, btn_c_i}),
      .rise_o (btn_rise)
   );

   delay_ctrl_regs u_delay_ctrl_regs (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .rise_i (btn_rise),
      .dip_i  (dip_i),
      .cfg    (u_status.cfg)
   );

   // ------------------------------
   // Alignment delays
   // ------------------------------
   variable_delay #(.WIDTH(`SYSELE_SAMPLE_W)) u_ad1_delay (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .din_i  (ad1_i),
      .sel_i  (u_status.ad1_delay),
      .dout_o (ad1_o)
   );

   variable_delay #(.WIDTH(`SYSELE_SAMPLE_W)) u_ad2_delay (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .din_i  (ad2_i),
      .sel_i  (u_status.ad2_delay),
      .dout_o (ad2_o)
   );

   variable_delay #(.WIDTH(1)) u_valid_delay (
      .clk_i  (clk_i),
      .rst_i  (rst_i),
      .din_i  (ad_valid_i),
      .sel_i  (u_status.valid_delay),
      .dout_o (ad_valid_o)
   );

   // ------------------------------
   // Debug
   // ------------------------------
   ber_counter u_ber_counter (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .sent_i  (ber_sent_i),
      .recv_i  (ber_recv_i),
      .valid_i (ber_valid_i),
      .ber     (u_status.ber)
   );

   // Shows the aligned samples, not the raw inputs
   led_debug_mux u_led_debug_mux (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .dip_i (dip_i),
      .ad1_i (ad1_o),
      .ad2_i (ad2_o),
      .view  (u_status.view),
      .led_o (led_o)
   );

endmodule

// File: tb_sysele.sv
// Drives clean button levels only and assumes a press reaches the settings within 12 cycles
`timescale 1ns/100ps

`include "sysele_consts.svh"

module tb_sysele;

   localparam int N_BURST  = 17;
   localparam int N_RAND2  = 40;
   localparam int N_WARM   = 60;
   localparam int N_PRESS3 = 30;
   localparam int N_ROUNDS = 6;
   localparam int N_ROUND  = 50;
   localparam int N_DIP5   = 200;
   localparam int LIMIT    = 8 + 20 + (6 * N_BURST + N_RAND2) * 25 + N_WARM
                             + N_PRESS3 * 20 + N_ROUNDS * (N_ROUND + 4) + N_DIP5 + 200;

   logic       clk_i;
   logic       rst_i;
   logic       btn_n_i;
   logic       btn_s_i;
   logic       btn_c_i;
   logic [7:0] dip_i;
   logic [7:0] ad1_i;
   logic [7:0] ad2_i;
   logic       ad_valid_i;
   logic [5:0] ber_sent_i;
   logic [5:0] ber_recv_i;
   logic       ber_valid_i;
   logic [7:0] ad1_o;
   logic [7:0] ad2_o;
   logic       ad_valid_o;
   logic [7:0] led_o;

   // Model state
   integer      seed;
   int          cyc;
   int          wd_cnt = 0;
   logic [7:0]  hist1 [64];
   logic [7:0]  hist2 [64];
   logic        histv [64];
   logic [3:0]  dly_m [3];
   logic [15:0] err_m;
   logic [15:0] words_m;
   logic        pend_act;
   int          pend_tgt;
   logic [3:0]  pend_val;
   logic        chk_on;
   logic        have_prev;
   logic        led_chk;
   logic        adc_on;
   logic [7:0]  sav_ad1;
   logic [7:0]  sav_ad2;
   logic        sav_v;
   logic [7:0]  show_codes [7] = '{`SYSELE_CODE_AD1, `SYSELE_CODE_AD2, `SYSELE_CODE_BER_ERR,
                                   `SYSELE_CODE_BER_WORDS, `SYSELE_CODE_DLY_AD1,
                                   `SYSELE_CODE_DLY_AD2, `SYSELE_CODE_DLY_VALID};

   sysele_top u_sysele_top (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .btn_n_i     (btn_n_i),
      .btn_s_i     (btn_s_i),
      .btn_c_i     (btn_c_i),
      .dip_i       (dip_i),
      .ad1_i       (ad1_i),
      .ad2_i       (ad2_i),
      .ad_valid_i  (ad_valid_i),
      .ber_sent_i  (ber_sent_i),
      .ber_recv_i  (ber_recv_i),
      .ber_valid_i (ber_valid_i),
      .ad1_o       (ad1_o),
      .ad2_o       (ad2_o),
      .ad_valid_o  (ad_valid_o),
      .led_o       (led_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #2 clk_i = ~clk_i;
   end

   // ------------------------------
   // Checking helpers
   // ------------------------------
   task automatic check_val(input string name, input logic [15:0] got,
                            input logic [15:0] exp);
      if (got !== exp) begin
         $display("** Error: %s got %h, expected %h", name, got, exp);
         $display("Simulation failed");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Simulation failed");
      $fatal(1, "run stopped");
   endtask

   always @(posedge clk_i) begin
      wd_cnt = wd_cnt + 1;
      if (wd_cnt >= LIMIT) begin
         abort_run("Timeout: the test did not finish within the cycle limit");
      end
   end

   function automatic logic [3:0] sat_step(input logic [3:0] v, input logic up);
      if (up) begin
         return (v == 4'd15) ? v : v + 4'd1;
      end else begin
         return (v == 4'd0) ? v : v - 4'd1;
      end
   endfunction

   function automatic int diff_bits(input logic [5:0] a, input logic [5:0] b);
      int n;
      n = 0;
      for (int i = 0; i < 6; i++) begin
         n = n + int'(a[i] != b[i]);
      end
      return n;
   endfunction

   function automatic logic [7:0] led_expect(input logic [7:0] dip, input logic [7:0] e1,
                                             input logic [7:0] e2);
      case (dip)
         `SYSELE_CODE_AD1:       return e1;
         `SYSELE_CODE_AD2:       return e2;
         `SYSELE_CODE_BER_ERR:   return err_m[7:0];
         `SYSELE_CODE_BER_WORDS: return words_m[7:0];
         `SYSELE_CODE_DLY_AD1:   return {4'd0, dly_m[0]};
         `SYSELE_CODE_DLY_AD2:   return {4'd0, dly_m[1]};
         `SYSELE_CODE_DLY_VALID: return {4'd0, dly_m[2]};
         default:                return 8'd0;
      endcase
   endfunction

   // ------------------------------
   // One clock cycle of model and checks
   // ------------------------------
   task automatic tick();
      int         k;
      int         s;
      logic [7:0] e1;
      logic [7:0] e2;
      logic       ev;
      @(posedge clk_i);
      #1;
      cyc = cyc + 1;
      // LEDs show a setting one cycle after it moved
      if (pend_act) begin
         if (led_o === {4'd0, pend_val}) begin
            dly_m[pend_tgt] = pend_val;
            pend_act = 1'b0;
         end else begin
            check_val("led_o", led_o, {4'd0, dly_m[pend_tgt]});
         end
      end
      // Model settings now match the previous cycle
      k = cyc - 1 - `SYSELE_DLY_MIN;
      e1 = hist1[(k - int'(dly_m[0])) & 63];
      e2 = hist2[(k - int'(dly_m[1])) & 63];
      ev = histv[(k - int'(dly_m[2])) & 63];
      if (have_prev) begin
         check_val("ad1_o", sav_ad1, e1);
         check_val("ad2_o", sav_ad2, e2);
         check_val("ad_valid_o", sav_v, ev);
      end
      if (led_chk) begin
         check_val("led_o", led_o, led_expect(dip_i, e1, e2));
      end
      if (ber_valid_i) begin
         s = int'(err_m) + diff_bits(ber_sent_i, ber_recv_i);
         err_m = (s > 65535) ? 16'hFFFF : 16'(s);
         if (words_m != 16'hFFFF) begin
            words_m = words_m + 16'd1;
         end
      end
      have_prev = chk_on;
      sav_ad1 = ad1_o;
      sav_ad2 = ad2_o;
      sav_v = ad_valid_o;
      ad1_i = adc_on ? 8'($random(seed)) : 8'd0;
      ad2_i = adc_on ? 8'($random(seed)) : 8'd0;
      ad_valid_i = adc_on ? 1'($random(seed)) : 1'b0;
      hist1[cyc & 63] = ad1_i;
      hist2[cyc & 63] = ad2_i;
      histv[cyc & 63] = ad_valid_i;
   endtask

   task automatic verify_settings();
      for (int t = 0; t < 3; t++) begin
         dip_i = 8'd128 + 8'(t);
         tick();
         check_val("led_o", led_o, {4'd0, dly_m[t]});
      end
   endtask

   // Button 0 north, 1 south, 2 centre
   task automatic press(input int btn, input logic [7:0] dip);
      int       t;
      logic [3:0] nv;
      dip_i = dip;
      tick();
      t = int'(dip[1:0]);
      if (btn == 2) begin
         dly_m = '{default: 4'd0};
      end else if (dip[7] && t != 3) begin
         nv = sat_step(dly_m[t], btn == 0);
         if (nv != dly_m[t]) begin
            pend_act = 1'b1;
            pend_tgt = t;
            pend_val = nv;
         end
      end
      btn_n_i = (btn == 0);
      btn_s_i = (btn == 1);
      btn_c_i = (btn == 2);
      repeat (6) tick();
      btn_n_i = 1'b0;
      btn_s_i = 1'b0;
      btn_c_i = 1'b0;
      repeat (6) tick();
      if (pend_act) begin
         abort_run("A button press never changed the targeted delay setting");
      end
   endtask

   task automatic random_press(input logic full);
      int         kind;
      int         t;
      logic [7:0] d;
      kind = $unsigned($random(seed)) % (full ? 10 : 7);
      t = $unsigned($random(seed)) % 3;
      d = 8'($random(seed));
      if (kind < 4) begin
         press(0, 8'd128 + 8'(t));
      end else if (kind < 7) begin
         press(1, 8'd128 + 8'(t));
      end else begin
         if (kind == 7) begin
            press(2, d);
         end else if (kind == 8) begin
            // Adjust bit clear
            press(t % 2, {1'b0, d[6:0]});
         end else begin
            press(t % 2, {1'b1, d[6:2], 2'b11});
         end
         repeat (8) tick();
         verify_settings();
      end
   endtask

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      seed = 20;
      rst_i = 1'b1;
      btn_n_i = 1'b0;
      btn_s_i = 1'b0;
      btn_c_i = 1'b0;
      dip_i = 8'd0;
      ad1_i = 8'd0;
      ad2_i = 8'd0;
      ad_valid_i = 1'b0;
      ber_sent_i = 6'd0;
      ber_recv_i = 6'd0;
      ber_valid_i = 1'b0;
      cyc = 0;
      for (int i = 0; i < 64; i++) begin
         hist1[i] = 8'd0;
         hist2[i] = 8'd0;
         histv[i] = 1'b0;
      end
      dly_m = '{default: 4'd0};
      err_m = 16'd0;
      words_m = 16'd0;
      pend_act = 1'b0;
      pend_tgt = 0;
      pend_val = 4'd0;
      chk_on = 1'b0;
      have_prev = 1'b0;
      led_chk = 1'b0;
      adc_on = 1'b0;
      repeat (8) tick();
      rst_i = 1'b0;
      chk_on = 1'b1;

      // Reset state
      tick();
      check_val("ad1_o", ad1_o, 8'd0);
      check_val("ad2_o", ad2_o, 8'd0);
      check_val("ad_valid_o", ad_valid_o, 1'b0);
      check_val("led_o", led_o, 8'd0);
      verify_settings();

      // Saturation bursts, then a random mix
      for (int t = 0; t < 3; t++) begin
         repeat (N_BURST) press(0, 8'd128 + 8'(t));
         verify_settings();
      end
      for (int t = 0; t < 3; t++) begin
         repeat (N_BURST) press(1, 8'd128 + 8'(t));
         verify_settings();
      end
      repeat (N_RAND2) random_press(1'b1);

      // Streaming samples while settings move
      adc_on = 1'b1;
      repeat (N_WARM) tick();
      repeat (N_PRESS3) begin
         random_press(1'b0);
         repeat ($unsigned($random(seed)) % 8) tick();
      end

      // BER traffic with quiet gaps
      led_chk = 1'b1;
      for (int r = 0; r < N_ROUNDS; r++) begin
         repeat (N_ROUND) begin
            dip_i = `SYSELE_CODE_BER_ERR + 8'($unsigned($random(seed)) % 2);
            ber_sent_i = 6'($random(seed));
            ber_recv_i = 6'($random(seed));
            ber_valid_i = 1'($random(seed));
            tick();
         end
         ber_valid_i = 1'b0;
         dip_i = `SYSELE_CODE_BER_ERR;
         tick();
         dip_i = `SYSELE_CODE_BER_WORDS;
         repeat (3) tick();
      end

      // Defined and undefined display codes
      repeat (N_DIP5) begin
         if ($random(seed) & 1) begin
            dip_i = show_codes[$unsigned($random(seed)) % 7];
         end else begin
            dip_i = 8'($random(seed));
         end
         tick();
      end
      repeat (4) tick();
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: variable_delay.sv
// Delay is SYSELE_DLY_MIN plus sel_i cycles, a new sel_i moves the tap in the same cycle
`timescale 1ns/100ps

`include "sysele_consts.svh"

module variable_delay
   import sysele_pkg::*;
#(
   parameter int WIDTH = `SYSELE_SAMPLE_W
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic [WIDTH-1:0] din_i,
   input  dly_sel_t         sel_i,
   output logic [WIDTH-1:0] dout_o
);

   // Enough stages for the largest setting
   localparam int DEPTH = `SYSELE_DLY_MIN + (1 << `SYSELE_DLY_SEL_W) - 1;

   // Stage k holds the input from k+1 cycles ago
   localparam int TAP_BASE = `SYSELE_DLY_MIN - 1;

   logic [WIDTH-1:0] line_q [DEPTH];

   // ------------------------------
   // Shift register
   // ------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         line_q <= '{default: '0};
      end else begin
         line_q[0] <= din_i;
         for (int k = 1; k < DEPTH; k++) begin
            line_q[k] <= line_q[k-1];
         end
      end
   end

   // Tap select
   assign dout_o = line_q[TAP_BASE + int'(sel_i)];

endmodule
